// ==== include/riscv_consts.svh ====
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// datapath width, one machine word
`define XLEN 32

// register file geometry
`define REG_ADDR_W 5 // rs1, rs2 and rd fields
`define REG_COUNT 32 // x0 is wired to zero

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// alu status bits N, Z, C and V
`define ALU_FLAGS_W 4

`endif

// ==== verilog/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

    // major opcodes of the supported subset, instr[6:0]
    typedef enum logic [6:0] {
        op_load   = 7'b0000011, // lw
        op_store  = 7'b0100011, // sw
        op_rtype  = 7'b0110011, // add sub and or slt
        op_itype  = 7'b0010011, // addi andi ori slti
        op_branch = 7'b1100011, // beq bne blt
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sub = 3'b001,
        alu_and = 3'b010,
        alu_or  = 3'b011,
        alu_slt = 3'b101 // signed compare
    } alu_op_e;

    typedef enum logic [1:0] {
        imm_i = 2'b00, // loads, alu immediates
        imm_s = 2'b01, // stores
        imm_b = 2'b10, // branches
        imm_j = 2'b11  // jal
    } imm_src_e;

    typedef enum logic [1:0] {
        res_alu = 2'b00,
        res_mem = 2'b01, // load data
        res_pc4 = 2'b10  // link address
    } result_src_e;

    typedef enum logic {
        src_reg = 1'b0, // rs2
        src_imm = 1'b1  // extended immediate
    } alu_src_e;

    // bit positions in the alu flag vector
    typedef enum logic [1:0] {
        flag_v = 2'd0,
        flag_c = 2'd1,
        flag_z = 2'd2,
        flag_n = 2'd3
    } flag_idx_e;

endpackage

`default_nettype wire

// ==== verilog/alu.sv ====
`default_nettype none

`include "riscv_consts.svh"

module alu (
    input  wire  [`XLEN-1:0]        a,
    input  wire  [`XLEN-1:0]        b,
    input  wire  riscv_pkg::alu_op_e alu_op,
    output logic [`XLEN-1:0]        result,
    output logic [`ALU_FLAGS_W-1:0] flags
);
    logic           subtract; // invert b and carry in
    logic [`XLEN-1:0] b_eff;
    logic [`XLEN:0]   sum;    // extra bit is the carry out
    logic           arith;    // flags C and V only mean something here
    logic           overflow;
    logic           less;     // signed a < b

    assign subtract = (alu_op == riscv_pkg::alu_sub) || (alu_op == riscv_pkg::alu_slt);
    assign b_eff    = subtract ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_eff} + {{`XLEN{1'b0}}, subtract}; // shared adder

    // operands agree in sign but the sum does not
    assign overflow = (a[`XLEN-1] ~^ b_eff[`XLEN-1]) & (sum[`XLEN-1] ^ a[`XLEN-1]);
    assign less     = sum[`XLEN-1] ^ overflow;
    assign arith    = (alu_op == riscv_pkg::alu_add) || subtract;

    always_comb begin
        case (alu_op)
            riscv_pkg::alu_add: result = sum[`XLEN-1:0];
            riscv_pkg::alu_sub: result = sum[`XLEN-1:0];
            riscv_pkg::alu_and: result = a & b;
            riscv_pkg::alu_or:  result = a | b;
            riscv_pkg::alu_slt: result = {{(`XLEN-1){1'b0}}, less};
            default:            result = sum[`XLEN-1:0];
        endcase
    end

    always_comb begin
        flags                    = '0;
        flags[riscv_pkg::flag_n] = result[`XLEN-1];
        flags[riscv_pkg::flag_z] = (result == '0);
        flags[riscv_pkg::flag_c] = arith & sum[`XLEN]; // carry, i.e. no borrow on sub
        flags[riscv_pkg::flag_v] = arith & overflow;
    end

endmodule

`default_nettype wire

// ==== verilog/extend.sv ====
`default_nettype none

`include "riscv_consts.svh"

module extend (
    input  wire  [`XLEN-1:0]         instr,
    input  wire  riscv_pkg::imm_src_e imm_src,
    output logic [`XLEN-1:0]         ext_imm
);
    logic [`XLEN-1:0] imm_i_val;
    logic [`XLEN-1:0] imm_s_val;
    logic [`XLEN-1:0] imm_b_val;
    logic [`XLEN-1:0] imm_j_val;

    // 12-bit immediate in instr[31:20]
    assign imm_i_val = {{(`XLEN-12){instr[31]}}, instr[31:20]};

    // store offset split around the rs2 field
    assign imm_s_val = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

    // branch offset, halfword aligned
    assign imm_b_val = {{(`XLEN-13){instr[31]}}, instr[31], instr[7],
                        instr[30:25], instr[11:8], 1'b0};

    // jal offset, 21 bits with zero lsb
    assign imm_j_val = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12],
                        instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (imm_src)
            riscv_pkg::imm_i: ext_imm = imm_i_val;
            riscv_pkg::imm_s: ext_imm = imm_s_val;
            riscv_pkg::imm_b: ext_imm = imm_b_val;
            riscv_pkg::imm_j: ext_imm = imm_j_val;
            default:          ext_imm = imm_i_val;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
`default_nettype none

`include "riscv_consts.svh"

module regfile (
    input  wire                    clk,
    input  wire  [`REG_ADDR_W-1:0] addr1, // rs1
    input  wire  [`REG_ADDR_W-1:0] addr2, // rs2
    input  wire  [`REG_ADDR_W-1:0] addr3, // rd
    input  wire  [`XLEN-1:0]       wd3,
    input  wire                    we,
    output logic [`XLEN-1:0]       rd1,
    output logic [`XLEN-1:0]       rd2
);
    logic [`XLEN-1:0] regs [`REG_COUNT]; // architectural registers, no reset

    // write lands at the clock edge, x0 writes dropped
    always_ff @(posedge clk) begin
        if (we && (addr3 != '0)) begin
            regs[addr3] <= wd3;
        end
    end

    // reads are combinational, x0 reads as zero
    assign rd1 = (addr1 == '0) ? '0 : regs[addr1];
    assign rd2 = (addr2 == '0) ? '0 : regs[addr2];

endmodule

`default_nettype wire

// ==== verilog/datapath.sv ====
`default_nettype none

`include "riscv_consts.svh"

module datapath (
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire  [`XLEN-1:0]               instr,
    input  wire  [`XLEN-1:0]               read_data,
    input  wire                            reg_write,
    input  wire  riscv_pkg::imm_src_e      imm_src,
    input  wire  riscv_pkg::alu_src_e      alu_src,
    input  wire  riscv_pkg::alu_op_e       alu_op,
    input  wire  riscv_pkg::result_src_e   result_src,
    input  wire                            pc_src,     // 1 takes pc + immediate
    output logic [`XLEN-1:0]               pc,
    output wire  [`XLEN-1:0]               alu_result,
    output wire  [`XLEN-1:0]               write_data, // rs2 value for stores
    output wire  [`ALU_FLAGS_W-1:0]        alu_flags
);
    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] pc_plus_4;
    logic [`XLEN-1:0] pc_target;  // branch and jal destination
    logic [`XLEN-1:0] ext_imm;
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] result;     // write-back value

    // pc register, the only state outside the register file
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus_4 = pc + `XLEN'd4;
    assign pc_target = pc + ext_imm;
    assign pc_next   = pc_src ? pc_target : pc_plus_4;

    regfile u_regfile (
        .clk   (clk),
        .addr1 (instr[19:15]),
        .addr2 (instr[24:20]),
        .addr3 (instr[11:7]),
        .wd3   (result),
        .we    (reg_write),
        .rd1   (src_a),
        .rd2   (write_data)
    );

    extend u_extend (
        .instr   (instr),
        .imm_src (imm_src),
        .ext_imm (ext_imm)
    );

    assign src_b = (alu_src == riscv_pkg::src_imm) ? ext_imm : write_data;

    alu u_alu (
        .a      (src_a),
        .b      (src_b),
        .alu_op (alu_op),
        .result (alu_result),
        .flags  (alu_flags)
    );

    always_comb begin
        case (result_src)
            riscv_pkg::res_alu: result = alu_result;
            riscv_pkg::res_mem: result = read_data;
            riscv_pkg::res_pc4: result = pc_plus_4; // jal link
            default:            result = alu_result;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/controller.sv ====
`default_nettype none

`include "riscv_consts.svh"

module controller (
    input  wire  [`XLEN-1:0]          instr,
    input  wire  [`ALU_FLAGS_W-1:0]   alu_flags,
    output logic                      reg_write,
    output logic                      mem_write,
    output riscv_pkg::imm_src_e       imm_src,
    output riscv_pkg::alu_src_e       alu_src,
    output riscv_pkg::alu_op_e        alu_op,
    output riscv_pkg::result_src_e    result_src,
    output logic                      pc_src
);
    riscv_pkg::opcode_e opcode;
    logic [2:0]         funct3;
    logic               funct7_5;    // selects sub on r-type
    logic [1:0]         alu_class;   // 00 add, 01 sub, 10 from funct fields
    logic               branch;
    logic               jump;
    logic               take_branch;

    assign opcode   = riscv_pkg::opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];

    // main decoder
    always_comb begin
        reg_write  = 1'b0;               // defaults give a no-op
        mem_write  = 1'b0;
        imm_src    = riscv_pkg::imm_i;
        alu_src    = riscv_pkg::src_reg;
        result_src = riscv_pkg::res_alu;
        alu_class  = 2'b00;
        branch     = 1'b0;
        jump       = 1'b0;
        case (opcode)
            riscv_pkg::op_load: begin
                reg_write  = 1'b1;
                alu_src    = riscv_pkg::src_imm; // base + offset
                result_src = riscv_pkg::res_mem;
            end
            riscv_pkg::op_store: begin
                mem_write = 1'b1;
                imm_src   = riscv_pkg::imm_s;
                alu_src   = riscv_pkg::src_imm;
            end
            riscv_pkg::op_rtype: begin
                reg_write = 1'b1;
                alu_class = 2'b10;
            end
            riscv_pkg::op_itype: begin
                reg_write = 1'b1;
                alu_src   = riscv_pkg::src_imm;
                alu_class = 2'b10;
            end
            riscv_pkg::op_branch: begin
                imm_src   = riscv_pkg::imm_b;
                alu_class = 2'b01;               // compare rs1 against rs2
                branch    = 1'b1;
            end
            riscv_pkg::op_jal: begin
                reg_write  = 1'b1;
                imm_src    = riscv_pkg::imm_j;
                result_src = riscv_pkg::res_pc4;
                jump       = 1'b1;
            end
            default: ; // unknown opcode only steps the pc
        endcase
    end

    // alu decoder
    always_comb begin
        case (alu_class)
            2'b00:   alu_op = riscv_pkg::alu_add;
            2'b01:   alu_op = riscv_pkg::alu_sub;
            default: begin
                case (funct3)
                    3'b000: begin
                        if ((opcode == riscv_pkg::op_rtype) && funct7_5) begin
                            alu_op = riscv_pkg::alu_sub;
                        end else begin
                            alu_op = riscv_pkg::alu_add; // addi never subtracts
                        end
                    end
                    3'b010:  alu_op = riscv_pkg::alu_slt;
                    3'b110:  alu_op = riscv_pkg::alu_or;
                    3'b111:  alu_op = riscv_pkg::alu_and;
                    default: alu_op = riscv_pkg::alu_add;
                endcase
            end
        endcase
    end

    // branch resolution from rs1 - rs2 flags
    always_comb begin
        case (funct3)
            3'b000:  take_branch = alu_flags[riscv_pkg::flag_z];  // beq
            3'b001:  take_branch = !alu_flags[riscv_pkg::flag_z]; // bne
            3'b100:  take_branch = alu_flags[riscv_pkg::flag_n] ^
                                   alu_flags[riscv_pkg::flag_v];  // blt, signed
            default: take_branch = 1'b0;
        endcase
    end

    assign pc_src = jump | (branch & take_branch);

endmodule

`default_nettype wire

// ==== verilog/riscv_core.sv ====
`default_nettype none

`include "riscv_consts.svh"

module riscv_core (
    input  wire                clk,
    input  wire                arst_n,
    input  wire  [`XLEN-1:0]   instr,      // from instruction memory
    input  wire  [`XLEN-1:0]   read_data,  // from data memory
    output wire  [`XLEN-1:0]   pc,
    output wire  [`XLEN-1:0]   data_addr,  // alu result
    output wire  [`XLEN-1:0]   write_data,
    output wire                mem_write
);
    logic                      reg_write;
    riscv_pkg::imm_src_e       imm_src;
    riscv_pkg::alu_src_e       alu_src;
    riscv_pkg::alu_op_e        alu_op;
    riscv_pkg::result_src_e    result_src;
    logic                      pc_src;
    logic [`ALU_FLAGS_W-1:0]   alu_flags;  // fed back for branch decisions

    controller u_controller (
        .instr      (instr),
        .alu_flags  (alu_flags),
        .reg_write  (reg_write),
        .mem_write  (mem_write),
        .imm_src    (imm_src),
        .alu_src    (alu_src),
        .alu_op     (alu_op),
        .result_src (result_src),
        .pc_src     (pc_src)
    );

    datapath u_datapath (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr      (instr),
        .read_data  (read_data),
        .reg_write  (reg_write),
        .imm_src    (imm_src),
        .alu_src    (alu_src),
        .alu_op     (alu_op),
        .result_src (result_src),
        .pc_src     (pc_src),
        .pc         (pc),
        .alu_result (data_addr),
        .write_data (write_data),
        .alu_flags  (alu_flags)
    );

endmodule

`default_nettype wire

// ==== test/riscv_core_tb.sv ====
`default_nettype none

`include "riscv_consts.svh"

module riscv_core_tb;
    localparam int clk_period   = 10;
    localparam int reset_cycles = 4;
    localparam logic [`XLEN-1:0] nop_instr = 32'h0000_0013; // addi x0, x0, 0

    logic             clk;
    logic             arst_n;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] read_data;
    wire  [`XLEN-1:0] pc;
    wire  [`XLEN-1:0] data_addr;
    wire  [`XLEN-1:0] write_data;
    wire              mem_write;

    // step table, one entry per instruction
    string            step_name[$];
    logic [`XLEN-1:0] step_instr[$];
    logic [`XLEN-1:0] step_rdata[$];     // load data presented with the step
    logic             step_we[$];
    logic [`XLEN-1:0] step_addr[$];
    logic [`XLEN-1:0] step_addr_mask[$]; // zero means don't care
    logic [`XLEN-1:0] step_wdata[$];
    logic [`XLEN-1:0] step_wdata_mask[$];
    logic [`XLEN-1:0] step_pc[$];        // pc after the rising edge

    logic [`XLEN-1:0] build_pc;          // pc tracked while the table is built
    bit               table_ready;
    int               pass_count;
    int               fail_count;
    int               step_errors;

    riscv_core DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr      (instr),
        .read_data  (read_data),
        .pc         (pc),
        .data_addr  (data_addr),
        .write_data (write_data),
        .mem_write  (mem_write)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [`XLEN-1:0] xorshift(input logic [`XLEN-1:0] x);
        logic [`XLEN-1:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // instruction encoders, field order per the base ISA formats
    function automatic logic [`XLEN-1:0] enc_r(input int f3, input int f7_5, input int rd,
                                              input int rs1, input int rs2);
        return {1'b0, f7_5[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], riscv_pkg::op_rtype};
    endfunction

    function automatic logic [`XLEN-1:0] enc_i(input riscv_pkg::opcode_e op, input int f3,
                                              input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [`XLEN-1:0] enc_s(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], riscv_pkg::op_store}; // sw
    endfunction

    function automatic logic [`XLEN-1:0] enc_b(input int f3, input int rs1, input int rs2,
                                              input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                riscv_pkg::op_branch};
    endfunction

    function automatic logic [`XLEN-1:0] enc_j(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], riscv_pkg::op_jal};
    endfunction

    task automatic push_step(input string name, input logic [`XLEN-1:0] ins,
                             input logic [`XLEN-1:0] rdata, input logic we,
                             input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] addr_mask,
                             input logic [`XLEN-1:0] wdata, input logic [`XLEN-1:0] wdata_mask,
                             input logic [`XLEN-1:0] next_pc);
        step_name.push_back(name);
        step_instr.push_back(ins);
        step_rdata.push_back(rdata);
        step_we.push_back(we);
        step_addr.push_back(addr);
        step_addr_mask.push_back(addr_mask);
        step_wdata.push_back(wdata);
        step_wdata_mask.push_back(wdata_mask);
        step_pc.push_back(next_pc);
        build_pc = next_pc;
    endtask

    // alu result shows on data_addr, no store
    task automatic step_alu(input string name, input logic [`XLEN-1:0] ins,
                            input logic [`XLEN-1:0] res);
        push_step(name, ins, '0, 1'b0, res, '1, '0, '0, build_pc + 32'd4);
    endtask

    task automatic step_load(input string name, input logic [`XLEN-1:0] ins,
                             input logic [`XLEN-1:0] rdata, input logic [`XLEN-1:0] addr);
        push_step(name, ins, rdata, 1'b0, addr, '1, '0, '0, build_pc + 32'd4);
    endtask

    task automatic step_store(input string name, input logic [`XLEN-1:0] ins,
                              input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] wdata);
        push_step(name, ins, '0, 1'b1, addr, '1, wdata, '1, build_pc + 32'd4);
    endtask

    task automatic step_branch(input string name, input logic [`XLEN-1:0] ins,
                               input bit taken, input int offset);
        push_step(name, ins, '0, 1'b0, '0, '0, '0, '0,
                  taken ? build_pc + offset : build_pc + 32'd4);
    endtask

    task automatic build_table();
        logic [`XLEN-1:0] ld0;
        logic [`XLEN-1:0] ld1;
        logic [`XLEN-1:0] ld2;
        logic [`XLEN-1:0] link;
        ld0 = xorshift(32'hc914_6041);
        ld1 = xorshift(ld0);
        ld2 = xorshift(ld1);
        build_pc = `RESET_PC;
        step_load("lw x1,16(x0)", enc_i(riscv_pkg::op_load, 2, 1, 0, 16), ld0, 32'd16);
        step_load("lw x2,4(x1)", enc_i(riscv_pkg::op_load, 2, 2, 1, 4), ld1, ld0 + 32'd4);
        step_alu("addi x3", enc_i(riscv_pkg::op_itype, 0, 3, 0, 100), 32'd100);
        step_alu("addi x4", enc_i(riscv_pkg::op_itype, 0, 4, 0, -7), 32'hffff_fff9);
        step_alu("add x5", enc_r(0, 0, 5, 1, 2), ld0 + ld1);
        step_alu("sub x6", enc_r(0, 1, 6, 1, 2), ld0 - ld1);
        step_alu("and x7", enc_r(7, 0, 7, 1, 2), ld0 & ld1);
        step_alu("or x8", enc_r(6, 0, 8, 1, 2), ld0 | ld1);
        step_alu("slt x9", enc_r(2, 0, 9, 4, 3), 32'd1);   // -7 < 100
        step_alu("slt x10", enc_r(2, 0, 10, 3, 4), 32'd0);
        step_alu("andi x11", enc_i(riscv_pkg::op_itype, 7, 11, 1, 255), ld0 & 32'h0ff);
        step_alu("ori x12", enc_i(riscv_pkg::op_itype, 6, 12, 3, 1792), 32'h764);
        step_alu("slti x13", enc_i(riscv_pkg::op_itype, 2, 13, 4, -1), 32'd1);
        step_alu("addi x0", enc_i(riscv_pkg::op_itype, 0, 0, 0, 55), 32'd55); // write dropped
        step_store("sw x2,0(x5)", enc_s(2, 5, 0), ld0 + ld1, ld1);
        step_store("sw x0,0(x6)", enc_s(0, 6, 0), ld0 - ld1, 32'd0);
        step_store("sw x1,0(x9)", enc_s(1, 9, 0), 32'd1, ld0);
        step_store("sw x1,0(x10)", enc_s(1, 10, 0), 32'd0, ld0);
        step_store("sw x13,0(x11)", enc_s(13, 11, 0), ld0 & 32'h0ff, 32'd1);
        step_store("sw x12,0(x7)", enc_s(12, 7, 0), ld0 & ld1, 32'h764);
        step_store("sw x3,0(x8)", enc_s(3, 8, 0), ld0 | ld1, 32'd100);
        step_store("sw x2,-12(x3)", enc_s(2, 3, -12), 32'd88, ld1);
        step_store("sw x0,8(x0)", enc_s(0, 0, 8), 32'd8, 32'd0); // x0 still zero
        step_branch("beq taken", enc_b(0, 3, 3, 16), 1'b1, 16);
        step_branch("beq not taken", enc_b(0, 3, 4, 16), 1'b0, 16);
        step_branch("bne taken", enc_b(1, 3, 4, -8), 1'b1, -8);
        step_branch("bne not taken", enc_b(1, 1, 1, 12), 1'b0, 12);
        step_branch("blt taken", enc_b(4, 4, 3, 20), 1'b1, 20);
        step_branch("blt not taken", enc_b(4, 3, 4, 20), 1'b0, 20); // unsigned would take it
        link = build_pc + 32'd4;                                    // rd gets pc + 4
        step_branch("jal x14", enc_j(14, 64), 1'b1, 64);
        step_branch("jal x0", enc_j(0, -32), 1'b1, -32);
        step_store("sw x14,0(x0)", enc_s(14, 0, 0), 32'd0, link);
        step_load("lw x15,0(x3)", enc_i(riscv_pkg::op_load, 2, 15, 3, 0), ld2, 32'd100);
        step_store("sw x15,-4(x3)", enc_s(15, 3, -4), 32'd96, ld2);
    endtask

    task automatic check_word(input string name, input string what,
                              input logic [`XLEN-1:0] ins, input logic [`XLEN-1:0] expected,
                              input logic [`XLEN-1:0] actual, input logic [`XLEN-1:0] mask);
        riscv_pkg::opcode_e op;
        op = riscv_pkg::opcode_e'(ins[6:0]);
        if ((actual & mask) !== (expected & mask)) begin
            $display("Mismatch %s (%s) %s: expected %h, actual %h",
                     name, op.name(), what, expected, actual);
            step_errors++;
        end
    endtask

    task automatic check_bit(input string name, input string what,
                             input logic [`XLEN-1:0] ins, input logic expected,
                             input logic actual);
        riscv_pkg::opcode_e op;
        op = riscv_pkg::opcode_e'(ins[6:0]);
        if (actual !== expected) begin
            $display("Mismatch %s (%s) %s: expected %b, actual %b",
                     name, op.name(), what, expected, actual);
            step_errors++;
        end
    endtask

    task automatic check_pc(input string name, input logic [`XLEN-1:0] expected);
        if ($isunknown(pc)) begin
            $display("%s: pc is unknown", name);
            step_errors++;
        end else begin
            check_word(name, "pc", instr, expected, pc, '1);
        end
    endtask

    task automatic finish_step(input string name);
        if (step_errors == 0) begin
            pass_count++;
            $display("ok    %s", name);
        end else begin
            fail_count++;
            $display("error %s", name);
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        instr       = nop_instr;
        read_data   = '0;
        pass_count  = 0;
        fail_count  = 0;
        step_errors = 0;
        build_table();
        table_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        check_pc("reset", `RESET_PC);
        finish_step("reset");
        arst_n = 1'b1;                            // released between edges
        for (int i = 0; i < step_name.size(); i++) begin
            instr       = step_instr[i];          // driven on the falling edge
            read_data   = step_rdata[i];
            step_errors = 0;
            #(clk_period / 2 - 1);                // just before the rising edge
            check_bit(step_name[i], "mem_write", step_instr[i], step_we[i], mem_write);
            check_word(step_name[i], "data_addr", step_instr[i], step_addr[i], data_addr,
                       step_addr_mask[i]);
            check_word(step_name[i], "write_data", step_instr[i], step_wdata[i], write_data,
                       step_wdata_mask[i]);
            @(posedge clk);
            #1;
            check_pc(step_name[i], step_pc[i]);
            finish_step(step_name[i]);
            @(negedge clk);
        end
        $display("%0d steps passed, %0d steps with errors", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((step_name.size() + reset_cycles + 20) * clk_period);
        $display("watchdog expired before the last step finished");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
verilog/riscv_pkg.sv
verilog/alu.sv
verilog/extend.sv
verilog/regfile.sv
verilog/datapath.sv
verilog/controller.sv
verilog/riscv_core.sv
test/riscv_core_tb.sv

// ==== Makefile ====
# Verilator simulation of the single-cycle RV32I core

VERILATOR ?= verilator
TOP       ?= riscv_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
